/* track_cfg.svh */
// build-time sizes and APB register map of the bbox tracking core
// include wherever a width or a register address is needed
`ifndef TRACK_CFG_SVH
`define TRACK_CFG_SVH

// ----------------------------------------------------------
// sizes
// ----------------------------------------------------------
`define TRK_PE_NUM      4  // lanes per set
`define TRK_MAX_BBOXES  8  // boxes per frame, also history depth
`define TRK_COORD_W     8
`define TRK_WEIGHT_W    4
`define TRK_SCORE_W     14 // worst case 2*15*510 = 15300
`define TRK_ID_W        6
`define TRK_IDX_W       3  // history index
`define TRK_CNT_W       4  // holds 0..8

// ----------------------------------------------------------
// APB word addresses
// ----------------------------------------------------------
`define TRK_ADDR_WPOS   8'h00
`define TRK_ADDR_WSIZE  8'h04
`define TRK_ADDR_TH     8'h08
`define TRK_ADDR_COUNT  8'h0C

`endif

/* track_pkg.sv */
// shared types of the tracking core
// modules import it in the body and use scoped names on their ports
`include "track_cfg.svh"

package track_pkg;

	typedef logic [`TRK_COORD_W-1:0]  coord_t;
	typedef logic [`TRK_WEIGHT_W-1:0] weight_t;
	typedef logic [`TRK_SCORE_W-1:0]  score_t;
	typedef logic [`TRK_ID_W-1:0]     track_id_t;
	typedef logic [`TRK_IDX_W-1:0]    hist_idx_t;
	typedef logic [`TRK_CNT_W-1:0]    bbox_cnt_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t w;
		coord_t h;
	} bbox_t; // 32 bits

	typedef struct packed {
		logic [`TRK_PE_NUM-1:0]  valid; // lane mask, all ones but the last set
		bbox_t [`TRK_PE_NUM-1:0] bbox;
	} bbox_set_t;

	typedef track_id_t [`TRK_PE_NUM-1:0] id_set_t; // lane 0 in the low bits

	// register values handed to the core
	typedef struct packed {
		weight_t   w_pos;     // on |dx| + |dy|
		weight_t   w_size;    // on |dw| + |dh|
		score_t    threshold; // inherit at or below
		bbox_cnt_t count;     // boxes per frame
	} track_cfg_t;

	typedef enum logic [1:0] {
		ST_WAIT_SET,
		ST_SCAN,
		ST_WRITE,
		ST_SWAP
	} core_state_e;

endpackage

/* track_apb_regs.sv */
// APB slave with the tracking weights, threshold and frame box count
// no wait states; bad writes answer with pslverr and leave the registers alone
`include "track_cfg.svh"

module track_apb_regs (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [7:0]            paddr_i,
	input  logic [31:0]           pwdata_i,
	output logic [31:0]           prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output track_pkg::track_cfg_t cfg_o
);
	import track_pkg::*;

	track_cfg_t cfg_q;
	logic       wr_acc;   // write in the access phase
	logic       addr_hit; // one of the four registers
	logic       cnt_bad;  // count outside 1..max

	assign wr_acc   = psel_i & penable_i & pwrite_i;
	assign addr_hit = (paddr_i == `TRK_ADDR_WPOS) | (paddr_i == `TRK_ADDR_WSIZE) |
	                  (paddr_i == `TRK_ADDR_TH) | (paddr_i == `TRK_ADDR_COUNT);
	assign cnt_bad  = (paddr_i == `TRK_ADDR_COUNT) &&
	                  ((pwdata_i == 32'd0) || (pwdata_i > `TRK_MAX_BBOXES));

	assign pready_o  = 1'b1;
	assign pslverr_o = wr_acc & (~addr_hit | cnt_bad);

	// ----------------------------------------------------------
	// register writes
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cfg_q.w_pos     <= weight_t'(1);
			cfg_q.w_size    <= weight_t'(1);
			cfg_q.threshold <= score_t'(20);
			cfg_q.count     <= bbox_cnt_t'(4); // one full set
		end else if (wr_acc && !pslverr_o) begin
			case (paddr_i)
				`TRK_ADDR_WPOS:  cfg_q.w_pos     <= pwdata_i[`TRK_WEIGHT_W-1:0];
				`TRK_ADDR_WSIZE: cfg_q.w_size    <= pwdata_i[`TRK_WEIGHT_W-1:0];
				`TRK_ADDR_TH:    cfg_q.threshold <= pwdata_i[`TRK_SCORE_W-1:0];
				`TRK_ADDR_COUNT: cfg_q.count     <= pwdata_i[`TRK_CNT_W-1:0];
				default: ;
			endcase
		end
	end

	// read mux, zero extended
	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			`TRK_ADDR_WPOS:  prdata_o[`TRK_WEIGHT_W-1:0] = cfg_q.w_pos;
			`TRK_ADDR_WSIZE: prdata_o[`TRK_WEIGHT_W-1:0] = cfg_q.w_size;
			`TRK_ADDR_TH:    prdata_o[`TRK_SCORE_W-1:0]  = cfg_q.threshold;
			`TRK_ADDR_COUNT: prdata_o[`TRK_CNT_W-1:0]    = cfg_q.count;
			default:         prdata_o = '0; // unmapped reads as zero
		endcase
	end

	assign cfg_o = cfg_q;

endmodule

/* track_core_fsm.sv */
// frame sequencer: accepts a set, runs the history scan, issues the write
// and swaps the history banks once the frame's last set is written
`include "track_cfg.svh"

module track_core_fsm (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  set_valid_i,
	input  track_pkg::track_cfg_t cfg_i,
	input  logic                  scan_last_i,
	input  track_pkg::bbox_cnt_t  prev_count_i,
	output logic                  set_ready_o,
	output logic                  scan_start_o,
	output logic                  lane_clear_o,
	output logic                  write_en_o,
	output logic                  swap_o,
	output track_pkg::track_cfg_t cfg_o
);
	import track_pkg::*;

	core_state_e state;
	core_state_e state_nxt;
	track_cfg_t  cfg_q;      // settings of the frame in flight
	bbox_cnt_t   boxes_done; // boxes of this frame already written
	logic        ready_q;
	logic        xfer;       // set accepted this clock
	logic        last_set;   // current set closes the frame

	assign xfer     = set_valid_i & ready_q;
	assign last_set = (boxes_done + bbox_cnt_t'(`TRK_PE_NUM)) >= cfg_q.count;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WAIT_SET: if (xfer) begin
				// empty history goes straight to the write
				state_nxt = (prev_count_i != '0) ? ST_SCAN : ST_WRITE;
			end
			ST_SCAN:  if (scan_last_i) state_nxt = ST_WRITE;
			ST_WRITE: state_nxt = last_set ? ST_SWAP : ST_WAIT_SET;
			ST_SWAP:  state_nxt = ST_WAIT_SET;
			default:  state_nxt = ST_WAIT_SET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state      <= ST_WAIT_SET;
			ready_q    <= 1'b0;
			boxes_done <= '0;
			cfg_q      <= '0;
		end else begin
			state   <= state_nxt;
			ready_q <= (state_nxt == ST_WAIT_SET);
			if (xfer && boxes_done == '0)
				cfg_q <= cfg_i; // frozen for the whole frame
			if (state == ST_WRITE)
				boxes_done <= last_set ? '0 : boxes_done + bbox_cnt_t'(`TRK_PE_NUM);
		end
	end

	assign set_ready_o  = ready_q;
	assign scan_start_o = xfer & (prev_count_i != '0);
	assign lane_clear_o = xfer;                // lanes take their box here
	assign write_en_o   = (state == ST_WRITE);
	assign swap_o       = (state == ST_SWAP);
	assign cfg_o        = cfg_q;

endmodule

/* track_scan_counter.sv */
// history index stepper for the scan phase
// presents 0..P-1 on consecutive cycles after a start pulse
`include "track_cfg.svh"

module track_scan_counter (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 scan_start_i,
	input  track_pkg::bbox_cnt_t prev_count_i,
	output track_pkg::hist_idx_t hist_idx_o,
	output logic                 scan_last_o,
	output logic                 step_o
);
	import track_pkg::*;

	hist_idx_t idx_q;
	logic      run_q;    // an index is on the bus
	bbox_cnt_t last_cnt; // P-1

	assign last_cnt    = prev_count_i - 1'b1;
	assign scan_last_o = run_q & (idx_q == last_cnt[`TRK_IDX_W-1:0]);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			run_q <= 1'b0;
			idx_q <= '0;
		end else if (scan_start_i) begin
			run_q <= 1'b1;
			idx_q <= '0;
		end else if (run_q) begin
			if (scan_last_o)
				run_q <= 1'b0; // stop on the last entry
			else
				idx_q <= idx_q + 1'b1;
		end
	end

	assign hist_idx_o = idx_q;
	assign step_o     = run_q;

endmodule

/* track_pe.sv */
// one tracking lane: scores its box against each presented history box
// and keeps the lowest score, the earlier index winning a tie
`include "track_cfg.svh"

module track_pe (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  clear_i,
	input  track_pkg::bbox_t      bbox_i,
	input  track_pkg::bbox_t      hist_bbox_i,
	input  track_pkg::hist_idx_t  hist_idx_i,
	input  logic                  step_i,
	input  track_pkg::track_cfg_t cfg_i,
	output logic                  match_o,
	output track_pkg::hist_idx_t  best_idx_o
);
	import track_pkg::*;

	bbox_t                 box_q;  // lane box, taken at the transfer
	score_t                best_q;
	hist_idx_t             idx_q;
	logic                  seen_q; // at least one entry scored
	coord_t                dx;
	coord_t                dy;
	coord_t                dw;
	coord_t                dh;
	logic [`TRK_COORD_W:0] pos_sum;
	logic [`TRK_COORD_W:0] size_sum;
	score_t                pos_term;
	score_t                size_term;
	score_t                score;

	function automatic coord_t absdiff(input coord_t a, input coord_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	// ----------------------------------------------------------
	// weighted distance
	// ----------------------------------------------------------
	assign dx        = absdiff(box_q.x, hist_bbox_i.x);
	assign dy        = absdiff(box_q.y, hist_bbox_i.y);
	assign dw        = absdiff(box_q.w, hist_bbox_i.w);
	assign dh        = absdiff(box_q.h, hist_bbox_i.h);
	assign pos_sum   = {1'b0, dx} + {1'b0, dy};
	assign size_sum  = {1'b0, dw} + {1'b0, dh};
	assign pos_term  = cfg_i.w_pos * pos_sum;   // widened to score width
	assign size_term = cfg_i.w_size * size_sum;
	assign score     = pos_term + size_term;

	always_ff @(posedge clk) begin
		if (!rst_n_i || clear_i)
			seen_q <= 1'b0;
		else if (step_i)
			seen_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (clear_i) begin
			box_q <= bbox_i;
		end else if (step_i && (!seen_q || score < best_q)) begin
			best_q <= score; // strict less keeps the lower index
			idx_q  <= hist_idx_i;
		end
	end

	assign match_o    = seen_q & (best_q <= cfg_i.threshold);
	assign best_idx_o = idx_q;

endmodule

/* track_history.sv */
// two-bank store of boxes and track IDs: previous frame on the read side,
// current frame filled on the write side; also hands out new IDs
`include "track_cfg.svh"

module track_history (
	input  logic                                   clk,
	input  logic                                   rst_n_i,
	input  track_pkg::bbox_set_t                   set_i,
	input  logic                                   load_i,
	input  track_pkg::hist_idx_t                   hist_idx_i,
	input  logic [`TRK_PE_NUM-1:0]                 match_i,
	input  track_pkg::hist_idx_t [`TRK_PE_NUM-1:0] best_idx_i,
	input  logic                                   write_en_i,
	input  logic                                   swap_i,
	output track_pkg::bbox_t                       hist_bbox_o,
	output track_pkg::bbox_cnt_t                   prev_count_o,
	output logic                                   ids_valid_o,
	output track_pkg::id_set_t                     ids_o
);
	import track_pkg::*;

	bbox_t     box_mem [2][`TRK_MAX_BBOXES];
	track_id_t id_mem  [2][`TRK_MAX_BBOXES];
	bbox_set_t set_q;      // set being processed
	logic      rd_bank;    // holds the previous frame
	logic      wr_bank;
	bbox_cnt_t wr_ptr;     // next free slot of the write bank
	bbox_cnt_t prev_cnt;
	track_id_t next_id;
	id_set_t   ids_q;
	logic      valid_q;
	id_set_t   lane_id;    // resolved ID per lane
	bbox_cnt_t lane_slot [`TRK_PE_NUM];
	bbox_cnt_t n_valid;
	track_id_t n_new;

	assign wr_bank     = ~rd_bank;
	assign hist_bbox_o = box_mem[rd_bank][hist_idx_i]; // shared by all lanes

	// inherit or allocate, new IDs in lane order
	always_comb begin
		n_valid = '0;
		n_new   = '0;
		lane_id = '0;
		for (int l = 0; l < `TRK_PE_NUM; l++) begin
			lane_slot[l] = wr_ptr + n_valid;
			if (set_q.valid[l]) begin
				if (match_i[l]) begin
					lane_id[l] = id_mem[rd_bank][best_idx_i[l]];
				end else begin
					lane_id[l] = next_id + n_new;
					n_new      = n_new + 1'b1;
				end
				n_valid = n_valid + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_bank  <= 1'b0;
			wr_ptr   <= '0;
			prev_cnt <= '0;
			next_id  <= track_id_t'(1);
			valid_q  <= 1'b0;
		end else begin
			valid_q <= write_en_i; // one pulse per set
			if (write_en_i) begin
				wr_ptr  <= wr_ptr + n_valid;
				next_id <= next_id + n_new;
			end
			if (swap_i) begin
				rd_bank  <= wr_bank;
				prev_cnt <= wr_ptr;
				wr_ptr   <= '0;
			end
		end
	end

	// ----------------------------------------------------------
	// storage and result word
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load_i)
			set_q <= set_i;
		if (write_en_i) begin
			ids_q <= lane_id;
			for (int l = 0; l < `TRK_PE_NUM; l++) begin
				if (set_q.valid[l]) begin
					box_mem[wr_bank][lane_slot[l][`TRK_IDX_W-1:0]] <= set_q.bbox[l];
					id_mem[wr_bank][lane_slot[l][`TRK_IDX_W-1:0]]  <= lane_id[l];
				end
			end
		end
	end

	assign prev_count_o = prev_cnt;
	assign ids_valid_o  = valid_q;
	assign ids_o        = ids_q;

endmodule

/* track_core.sv */
// top of the bbox tracking core: APB registers, frame FSM, scan counter,
// one scoring lane per set position and the two-bank history
`include "track_cfg.svh"

module track_core (
	input  logic                 clk,
	input  logic                 rst_n_i,
	// APB
	input  logic                 psel_i,
	input  logic                 penable_i,
	input  logic                 pwrite_i,
	input  logic [7:0]           paddr_i,
	input  logic [31:0]          pwdata_i,
	output logic [31:0]          prdata_o,
	output logic                 pready_o,
	output logic                 pslverr_o,
	// set input
	input  logic                 set_valid_i,
	output logic                 set_ready_o,
	input  track_pkg::bbox_set_t set_i,
	// results
	output logic                 ids_valid_o,
	output track_pkg::id_set_t   ids_o
);
	import track_pkg::*;

	track_cfg_t                   cfg_reg;    // live register values
	track_cfg_t                   cfg_lat;    // frame copy from the FSM
	logic                         scan_start;
	logic                         scan_last;
	logic                         scan_step;
	logic                         lane_clear;
	logic                         write_en;
	logic                         swap;
	hist_idx_t                    hist_idx;
	bbox_t                        hist_bbox;
	bbox_cnt_t                    prev_count;
	logic [`TRK_PE_NUM-1:0]       match;
	hist_idx_t [`TRK_PE_NUM-1:0]  best_idx;

	track_apb_regs track_apb_regs_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o), .cfg_o(cfg_reg)
	);

	track_core_fsm track_core_fsm_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.set_valid_i(set_valid_i), .cfg_i(cfg_reg),
		.scan_last_i(scan_last), .prev_count_i(prev_count),
		.set_ready_o(set_ready_o), .scan_start_o(scan_start),
		.lane_clear_o(lane_clear), .write_en_o(write_en),
		.swap_o(swap), .cfg_o(cfg_lat)
	);

	track_scan_counter track_scan_counter_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.scan_start_i(scan_start), .prev_count_i(prev_count),
		.hist_idx_o(hist_idx), .scan_last_o(scan_last), .step_o(scan_step)
	);

	// one lane per set position
	for (genvar g = 0; g < `TRK_PE_NUM; g++) begin : g_lane
		track_pe track_pe_inst (
			.clk(clk), .rst_n_i(rst_n_i),
			.clear_i(lane_clear), .bbox_i(set_i.bbox[g]),
			.hist_bbox_i(hist_bbox), .hist_idx_i(hist_idx),
			.step_i(scan_step), .cfg_i(cfg_lat),
			.match_o(match[g]), .best_idx_o(best_idx[g])
		);
	end

	track_history track_history_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.set_i(set_i), .load_i(lane_clear), .hist_idx_i(hist_idx),
		.match_i(match), .best_idx_i(best_idx),
		.write_en_i(write_en), .swap_i(swap),
		.hist_bbox_o(hist_bbox), .prev_count_o(prev_count),
		.ids_valid_o(ids_valid_o), .ids_o(ids_o)
	);

endmodule

/* tb_track_core.sv */
// testbench for the bbox tracking core: APB register checks, then a run of
// frames whose IDs and latency are compared with a model of the matching rules
`include "track_cfg.svh"

module tb_track_core;
	timeunit 1ns;
	timeprecision 1ps;
	import track_pkg::*;

	localparam int PE    = `TRK_PE_NUM;
	localparam int DEPTH = `TRK_MAX_BBOXES;
	localparam int LIMIT = 200; // cycles allowed per wait

	logic          clk;
	logic          rst_n_i;
	logic          psel_i;
	logic          penable_i;
	logic          pwrite_i;
	logic [7:0]    paddr_i;
	logic [31:0]   pwdata_i;
	logic [31:0]   prdata_o;
	logic          pready_o;
	logic          pslverr_o;
	logic          set_valid_i;
	logic          set_ready_o;
	bbox_set_t     set_i;
	logic          ids_valid_o;
	id_set_t       ids_o;

	integer        seed;
	int            cyc = 0;       // posedge count, read at negedges
	int            errors;
	int            checks;
	int            timeouts;
	int            exp_ready_cyc; // cycle where set_ready_o should come back

	// ----------------------------------------------------------
	// reference model state
	// ----------------------------------------------------------
	bbox_t         prev_box [DEPTH];
	track_id_t     prev_id  [DEPTH];
	int            prev_cnt;
	bbox_t         cur_box  [DEPTH];
	track_id_t     cur_id   [DEPTH];
	int            cur_cnt;
	track_id_t     next_id;
	track_cfg_t    reg_mirror;      // what the registers should hold
	track_cfg_t    frame_cfg;       // copy taken at a frame's first set
	bbox_t         frame_box [DEPTH]; // boxes of the frame about to go out
	id_set_t       exp_ids_q [$];
	logic [PE-1:0] exp_mask_q [$];
	int            exp_cyc_q [$];  // transfer cycle
	int            exp_p_q [$];    // history size seen by that set

	track_core track_core_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic int absd(input coord_t a, input coord_t b);
		int d;
		d = int'(a) - int'(b);
		return (d < 0) ? -d : d;
	endfunction

	// expected IDs of one set; appends the set to the model's current frame
	function automatic id_set_t expect_ids(input bbox_t pb [DEPTH], input track_id_t pid [DEPTH],
			input int pcnt, input bbox_set_t s, input track_cfg_t c);
		id_set_t ids;
		int      best;
		int      bi;
		int      sc;
		ids = '0;
		for (int l = 0; l < PE; l++) begin
			if (s.valid[l]) begin
				best = -1;
				bi   = 0;
				for (int k = 0; k < pcnt; k++) begin
					sc = int'(c.w_pos) * (absd(s.bbox[l].x, pb[k].x) + absd(s.bbox[l].y, pb[k].y))
					   + int'(c.w_size) * (absd(s.bbox[l].w, pb[k].w) + absd(s.bbox[l].h, pb[k].h));
					if (best < 0 || sc < best) begin // first lowest wins
						best = sc;
						bi   = k;
					end
				end
				if (best >= 0 && best <= int'(c.threshold)) begin
					ids[l] = pid[bi];
				end else begin
					ids[l]  = next_id; // fresh track
					next_id = next_id + 1'b1;
				end
				cur_box[cur_cnt] = s.bbox[l];
				cur_id[cur_cnt]  = ids[l];
				cur_cnt++;
			end
		end
		return ids;
	endfunction

	function automatic coord_t rand_coord(input int lo, input int span);
		return coord_t'(lo + int'($unsigned($random(seed)) % span));
	endfunction

	function automatic coord_t jitter(input coord_t v);
		return coord_t'(int'(v) + int'($unsigned($random(seed)) % 5) - 2); // -2..+2
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ----------------------------------------------------------
	// APB access, called and returning at a falling edge
	// ----------------------------------------------------------
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
			input logic exp_err, input logic [31:0] exp_rd);
		int n;
		psel_i    = 1'b1; // setup
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = data;
		@(negedge clk);
		penable_i = 1'b1; // access
		n = 0;
		while (!pready_o && n < LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!pready_o) begin
			$display("APB access to %0h never saw pready_o", addr);
			timeouts++;
			finish_run();
		end else begin
			@(negedge clk); // access taken, bus still held
			check_eq("pslverr_o", pslverr_o, exp_err);
			if (!wr)
				check_eq("prdata_o", prdata_o, exp_rd);
			psel_i    = 1'b0;
			penable_i = 1'b0;
			pwrite_i  = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		apb_access(1'b1, addr, data, exp_err, '0);
		if (!exp_err) begin
			case (addr)
				`TRK_ADDR_WPOS:  reg_mirror.w_pos     = data[`TRK_WEIGHT_W-1:0];
				`TRK_ADDR_WSIZE: reg_mirror.w_size    = data[`TRK_WEIGHT_W-1:0];
				`TRK_ADDR_TH:    reg_mirror.threshold = data[`TRK_SCORE_W-1:0];
				`TRK_ADDR_COUNT: reg_mirror.count     = data[`TRK_CNT_W-1:0];
				default: ;
			endcase
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
		apb_access(1'b0, addr, '0, 1'b0, exp);
	endtask

	// ----------------------------------------------------------
	// set and frame stimulus
	// ----------------------------------------------------------
	task automatic send_set(input bbox_set_t s, input bit b2b, input bit closes);
		int n;
		set_i       = s;
		set_valid_i = 1'b1; // held until accepted
		n = 0;
		while (!set_ready_o && n < LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!set_ready_o) begin
			$display("set never accepted, set_ready_o stayed low");
			timeouts++;
			finish_run();
		end else begin
			if (b2b)
				check_eq("set_ready_o rise cycle", cyc, exp_ready_cyc);
			exp_ids_q.push_back(expect_ids(prev_box, prev_id, prev_cnt, s, frame_cfg));
			exp_mask_q.push_back(s.valid);
			exp_cyc_q.push_back(cyc);     // transfer at the coming posedge
			exp_p_q.push_back(prev_cnt);
			exp_ready_cyc = cyc + prev_cnt + 2 + (closes ? 1 : 0); // swap adds one
			@(negedge clk);
			set_valid_i = 1'b0;
		end
	endtask

	task automatic send_frame(input int cnt, input bit first_b2b);
		bbox_set_t s;
		int        nsets;
		nsets     = (cnt + PE - 1) / PE;
		frame_cfg = reg_mirror; // core latches at the first set
		for (int k = 0; k < nsets; k++) begin
			for (int l = 0; l < PE; l++) begin
				s.valid[l] = (k * PE + l < cnt);
				s.bbox[l]  = s.valid[l] ? frame_box[k * PE + l] : bbox_t'($random(seed));
			end
			send_set(s, (k > 0) || first_b2b, k == nsets - 1);
		end
		for (int i = 0; i < cur_cnt; i++) begin // bank swap
			prev_box[i] = cur_box[i];
			prev_id[i]  = cur_id[i];
		end
		prev_cnt = cur_cnt;
		cur_cnt  = 0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_ids_q.size() != 0 && n < LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_ids_q.size() != 0) begin
			$display("results still missing after %0d cycles", LIMIT);
			timeouts++;
			finish_run();
		end
	endtask

	task automatic fill_fresh(input int cnt);
		for (int i = 0; i < cnt; i++) begin
			frame_box[i].x = rand_coord(10, 236);
			frame_box[i].y = rand_coord(10, 236);
			frame_box[i].w = rand_coord(8, 60);
			frame_box[i].h = rand_coord(8, 60);
		end
	endtask

	task automatic fill_jitter(input int cnt);
		for (int i = 0; i < cnt; i++) begin
			frame_box[i].x = jitter(frame_box[i].x);
			frame_box[i].y = jitter(frame_box[i].y);
			frame_box[i].w = jitter(frame_box[i].w);
			frame_box[i].h = jitter(frame_box[i].h);
		end
	endtask

	task automatic fill_far(input int cnt);
		for (int i = 0; i < cnt; i++) begin
			frame_box[i].x = frame_box[i].x ^ 8'h80; // 128 away
			frame_box[i].y = frame_box[i].y ^ 8'h80;
		end
	endtask

	// ----------------------------------------------------------
	// result comparison
	// ----------------------------------------------------------
	initial begin : compare_results
		int            idle;
		id_set_t       exp;
		logic [PE-1:0] mask;
		int            xcyc;
		int            p;
		idle = 0;
		forever begin
			@(negedge clk);
			if (ids_valid_o) begin
				idle = 0;
				if (exp_ids_q.size() == 0) begin
					errors++;
					$display("unexpected ids_valid_o pulse at %0t", $time);
				end else begin
					exp  = exp_ids_q.pop_front();
					mask = exp_mask_q.pop_front();
					xcyc = exp_cyc_q.pop_front();
					p    = exp_p_q.pop_front();
					for (int l = 0; l < PE; l++)
						if (mask[l])
							check_eq($sformatf("ids_o[%0d]", l), ids_o[l], exp[l]);
					check_eq("ids_valid_o latency", cyc - xcyc, p + 2);
				end
			end else if (exp_ids_q.size() != 0) begin
				idle++;
				if (idle > LIMIT) begin
					$display("ids_valid_o never came for a pending set");
					timeouts++;
					finish_run();
				end
			end
		end
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin : stimulus
		seed        = 32'ha98d_60da;
		rst_n_i     = 1'b0;
		psel_i      = 1'b0;
		penable_i   = 1'b0;
		pwrite_i    = 1'b0;
		paddr_i     = '0;
		pwdata_i    = '0;
		set_valid_i = 1'b0;
		set_i       = '0;
		errors      = 0;
		checks      = 0;
		timeouts    = 0;
		prev_cnt    = 0;
		cur_cnt     = 0;
		next_id     = track_id_t'(1);
		reg_mirror  = '{w_pos: 1, w_size: 1, threshold: 20, count: 4};
		repeat (3) @(negedge clk);
		rst_n_i = 1'b1;
		check_eq("ids_valid_o", ids_valid_o, 1'b0);
		check_eq("pslverr_o", pslverr_o, 1'b0);
		check_eq("set_ready_o", set_ready_o, 1'b0);

		// registers: defaults, writes, rejected writes
		apb_read(`TRK_ADDR_WPOS, 32'd1);
		apb_read(`TRK_ADDR_TH, 32'd20);
		apb_read(`TRK_ADDR_COUNT, 32'd4);
		apb_write(`TRK_ADDR_WPOS, 32'd2, 1'b0);
		apb_read(`TRK_ADDR_WPOS, 32'd2);
		apb_write(`TRK_ADDR_WSIZE, 32'd3, 1'b0);
		apb_read(`TRK_ADDR_WSIZE, 32'd3);
		apb_write(`TRK_ADDR_COUNT, 32'd8, 1'b0);
		apb_write(8'h10, 32'd5, 1'b1);           // unmapped
		apb_write(`TRK_ADDR_COUNT, 32'd0, 1'b1);
		apb_write(`TRK_ADDR_COUNT, 32'd9, 1'b1);
		apb_read(`TRK_ADDR_COUNT, 32'd8);         // untouched by bad writes

		fill_fresh(8);
		frame_box[5] = frame_box[1]; // twin entry, exercises the tie rule
		send_frame(8, 1'b0);          // all new, IDs 1..8
		wait_drain();
		fill_jitter(8);
		send_frame(8, 1'b0);          // inherits
		wait_drain();
		fill_far(8);
		send_frame(8, 1'b0);          // beyond threshold, fresh IDs
		wait_drain();
		apb_write(`TRK_ADDR_TH, 32'd4000, 1'b0);
		apb_read(`TRK_ADDR_TH, 32'd4000);
		fill_far(8);
		send_frame(8, 1'b0);          // same move now matches
		wait_drain();

		// five-box frames, partial second set
		apb_write(`TRK_ADDR_TH, 32'd20, 1'b0);
		apb_write(`TRK_ADDR_COUNT, 32'd5, 1'b0);
		fill_fresh(5);
		send_frame(5, 1'b0);
		fill_jitter(5);
		send_frame(5, 1'b1);          // held through write and swap
		wait_drain();
		repeat (4) @(negedge clk);    // room for a stray pulse
		finish_run();
	end

endmodule

/* list.f */
+incdir+.
track_pkg.sv
track_apb_regs.sv
track_core_fsm.sv
track_scan_counter.sv
track_pe.sv
track_history.sv
track_core.sv
tb_track_core.sv

/* run.sh */
#!/bin/sh
# build the tracking core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_track_core \
	-Mdir obj_dir -o tb_track_core \
	&& ./obj_dir/tb_track_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^TB PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
